//--- common/exec_pkg.sv
// ==========================================================================
// Shared widths, field layouts, encodings and result records of the
// execute stage, referenced by scoped name from every stage module
// ==========================================================================

package exec_pkg;

    localparam int word_width     = 32;
    localparam int reg_addr_width = 4;
    localparam int operand_width  = 12;  // Data-processing operand2 field
    localparam int offset_width   = 24;  // Branch offset field
    localparam int pc_reg         = 15;
    localparam int link_reg       = 14;
    localparam int pc_ahead       = 8;   // Fetch PC runs two words ahead

    typedef logic [word_width-1:0]     word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // ARM condition field, 1111 falls through to always
    typedef enum logic [3:0] {
        cond_eq = 4'b0000,
        cond_ne = 4'b0001,
        cond_cs = 4'b0010,
        cond_cc = 4'b0011,
        cond_mi = 4'b0100,
        cond_pl = 4'b0101,
        cond_vs = 4'b0110,
        cond_vc = 4'b0111,
        cond_hi = 4'b1000,
        cond_ls = 4'b1001,
        cond_ge = 4'b1010,
        cond_lt = 4'b1011,
        cond_gt = 4'b1100,
        cond_le = 4'b1101,
        cond_al = 4'b1110
    } cond_e;

    // Instruction bits 27:26
    typedef enum logic [1:0] {
        fmt_data   = 2'b00,
        fmt_memory = 2'b01,
        fmt_branch = 2'b10
    } format_e;

    typedef enum logic [3:0] {
        op_eor = 4'b0001,
        op_sub = 4'b0010,
        op_add = 4'b0100,
        op_tst = 4'b1000,
        op_teq = 4'b1001,
        op_cmp = 4'b1010,
        op_orr = 4'b1100,
        op_mov = 4'b1101,
        op_bic = 4'b1110,
        op_mvn = 4'b1111
    } dataproc_op_e;

    typedef enum logic [1:0] {
        shift_lsl = 2'b00,
        shift_lsr = 2'b01,
        shift_asr = 2'b10,
        shift_ror = 2'b11
    } shift_e;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } cpsr_t;

    typedef struct packed {
        cond_e                    cond;
        format_e                  format;
        logic                     imm;
        dataproc_op_e             opcode;
        logic                     s;
        reg_addr_t                rn;
        reg_addr_t                rd;
        logic [operand_width-1:0] operand2;
    } dp_inst_t;

    typedef struct packed {
        cond_e                   cond;
        format_e                 format;
        logic                    fixed_one;  // Bit 25, set in every branch
        logic                    link;
        logic [offset_width-1:0] offset;
    } br_inst_t;

    // Two readings of the operand2 field
    typedef struct packed {
        logic [3:0] rotate;
        logic [7:0] imm8;
    } imm_operand_t;

    typedef struct packed {
        logic [4:0] amount;
        shift_e     kind;
        logic       reg_amount;  // Shift by register, not supported here
        reg_addr_t  rm;
    } reg_operand_t;

    typedef struct packed {
        logic      write_rd;
        reg_addr_t rd;
        word_t     value;
        cpsr_t     flags;
    } dp_result_t;

    typedef struct packed {
        logic  link;
        word_t new_pc;
        word_t link_value;
    } br_result_t;

    typedef struct packed {
        logic      update_rd;
        reg_addr_t rd_addr;
        word_t     rd_value;
        logic      update_pc;
        word_t     new_pc;
        logic      flush_for_pc;
    } exec_out_t;

endpackage

//--- dataproc/operand_shifter.sv
// ==========================================================================
// Second operand of a data-processing instruction, from a rotated
// immediate or a shifted Rm, all combinational
// ==========================================================================
`timescale 1ns/1ps

module operand_shifter (
    input  logic [exec_pkg::operand_width-1:0] operand_field,
    input  logic                               imm,
    input  exec_pkg::word_t                    rm_value,
    output exec_pkg::word_t                    operand2
);

    exec_pkg::imm_operand_t imm_view;
    exec_pkg::reg_operand_t reg_view;
    exec_pkg::word_t        imm_word;
    exec_pkg::word_t        shifted;

    // Rotate by doubling the word, so an amount of 0 is a plain copy
    function automatic exec_pkg::word_t rotate_right(
        input exec_pkg::word_t value,
        input logic [4:0]      amount
    );
        logic [2*exec_pkg::word_width-1:0] doubled;
        doubled = {value, value} >> amount;
        return doubled[exec_pkg::word_width-1:0];
    endfunction

    assign imm_view = exec_pkg::imm_operand_t'(operand_field);
    assign reg_view = exec_pkg::reg_operand_t'(operand_field);

    assign imm_word = {{(exec_pkg::word_width-8){1'b0}}, imm_view.imm8};

    always_comb begin
        case (reg_view.kind)
            exec_pkg::shift_lsl: shifted = rm_value << reg_view.amount;
            exec_pkg::shift_lsr: shifted = rm_value >> reg_view.amount;
            exec_pkg::shift_asr: begin
                // Keep the sign bit
                shifted = exec_pkg::word_t'($signed(rm_value) >>> reg_view.amount);
            end
            exec_pkg::shift_ror: shifted = rotate_right(rm_value, reg_view.amount);
            default:             shifted = rm_value;
        endcase
    end

    // Immediate rotate is twice the 4-bit field
    assign operand2 = imm ? rotate_right(imm_word, {imm_view.rotate, 1'b0}) : shifted;

endmodule

//--- dataproc/dataproc_alu.sv
// ==========================================================================
// Data-processing ALU: result, Rd write flag and candidate NZCV flags,
// combinational, committed only by the commit stage
// ==========================================================================
`timescale 1ns/1ps

module dataproc_alu (
    input  exec_pkg::dp_inst_t   inst,
    input  exec_pkg::word_t      rn_value,
    input  exec_pkg::word_t      rm_value,
    input  exec_pkg::cpsr_t      cpsr,
    output exec_pkg::dp_result_t result
);

    exec_pkg::word_t               operand2;
    logic [exec_pkg::word_width:0] sum;   // Carry out in the top bit
    logic [exec_pkg::word_width:0] diff;  // Borrow in the top bit
    exec_pkg::word_t               value;
    logic                          write_rd;
    logic                          carry;
    logic                          overflow;
    logic                          add_overflow;
    logic                          sub_overflow;

    operand_shifter u_operand_shifter (
        .operand_field (inst.operand2),
        .imm           (inst.imm),
        .rm_value      (rm_value),
        .operand2      (operand2)
    );

    assign sum  = {1'b0, rn_value} + {1'b0, operand2};
    assign diff = {1'b0, rn_value} - {1'b0, operand2};

    // Signed overflow from the operand and result signs
    assign add_overflow = (rn_value[exec_pkg::word_width-1] == operand2[exec_pkg::word_width-1])
                        && (sum[exec_pkg::word_width-1] != rn_value[exec_pkg::word_width-1]);
    assign sub_overflow = (rn_value[exec_pkg::word_width-1] != operand2[exec_pkg::word_width-1])
                        && (diff[exec_pkg::word_width-1] != rn_value[exec_pkg::word_width-1]);

    always_comb begin
        write_rd = 1'b1;
        carry    = cpsr.c;  // C and V kept unless arithmetic
        overflow = cpsr.v;
        case (inst.opcode)
            exec_pkg::op_eor: value = rn_value ^ operand2;
            exec_pkg::op_sub, exec_pkg::op_cmp: begin
                value    = diff[exec_pkg::word_width-1:0];
                carry    = ~diff[exec_pkg::word_width];  // No borrow
                overflow = sub_overflow;
                write_rd = (inst.opcode == exec_pkg::op_sub);
            end
            exec_pkg::op_add: begin
                value    = sum[exec_pkg::word_width-1:0];
                carry    = sum[exec_pkg::word_width];
                overflow = add_overflow;
            end
            exec_pkg::op_tst: begin
                value    = rn_value & operand2;
                write_rd = 1'b0;
            end
            exec_pkg::op_teq: begin
                value    = rn_value ^ operand2;
                write_rd = 1'b0;
            end
            exec_pkg::op_orr: value = rn_value | operand2;
            exec_pkg::op_mov: value = operand2;
            exec_pkg::op_bic: value = rn_value & ~operand2;
            exec_pkg::op_mvn: value = ~operand2;
            default: begin
                // AND, RSB and friends are not implemented
                value    = rn_value;
                write_rd = 1'b0;
            end
        endcase
    end

    assign result.write_rd = write_rd;
    assign result.rd       = inst.rd;
    assign result.value    = value;
    assign result.flags.n  = value[exec_pkg::word_width-1];
    assign result.flags.z  = (value == '0);
    assign result.flags.c  = carry;
    assign result.flags.v  = overflow;

endmodule

//--- logic/branch_unit.sv
// ==========================================================================
// B/BL target and return address, combinational from the fetch PC
// ==========================================================================
`timescale 1ns/1ps

module branch_unit (
    input  exec_pkg::br_inst_t   inst,
    input  exec_pkg::word_t      pc,
    output exec_pkg::br_result_t result
);

    localparam int ext_width = exec_pkg::word_width - exec_pkg::offset_width - 2;

    exec_pkg::word_t byte_offset;
    exec_pkg::word_t inst_addr;

    // Word offset, sign extended and scaled to bytes
    assign byte_offset = {
        {ext_width{inst.offset[exec_pkg::offset_width-1]}},
        inst.offset,
        2'b00
    };

    // Incoming pc is already pc_ahead past the branch itself
    assign inst_addr = pc - exec_pkg::word_t'(exec_pkg::pc_ahead);

    assign result.link       = inst.link;
    assign result.new_pc     = pc + byte_offset;
    assign result.link_value = inst_addr + exec_pkg::word_t'(4);  // Next instruction

endmodule

//--- logic/exec_commit.sv
// ==========================================================================
// Commit side of the execute stage: condition check against the CPSR,
// result select by format, and all output registers
// ==========================================================================
`timescale 1ns/1ps

module exec_commit (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 enable,
    input  exec_pkg::word_t      inst,
    input  exec_pkg::dp_result_t dp,
    input  exec_pkg::br_result_t br,
    output logic                 ready,
    output exec_pkg::cpsr_t      cpsr,
    output logic                 condition_passes,
    output exec_pkg::word_t      executor_inst,
    output exec_pkg::exec_out_t  out
);

    exec_pkg::dp_inst_t  dp_view;
    logic                cond_ok;
    logic                execute;
    exec_pkg::exec_out_t next_out;
    exec_pkg::cpsr_t     next_cpsr;

    assign dp_view = exec_pkg::dp_inst_t'(inst);

    // Flags as left by the previous instruction
    always_comb begin
        case (dp_view.cond)
            exec_pkg::cond_eq: cond_ok = cpsr.z;
            exec_pkg::cond_ne: cond_ok = ~cpsr.z;
            exec_pkg::cond_cs: cond_ok = cpsr.c;
            exec_pkg::cond_cc: cond_ok = ~cpsr.c;
            exec_pkg::cond_mi: cond_ok = cpsr.n;
            exec_pkg::cond_pl: cond_ok = ~cpsr.n;
            exec_pkg::cond_vs: cond_ok = cpsr.v;
            exec_pkg::cond_vc: cond_ok = ~cpsr.v;
            exec_pkg::cond_hi: cond_ok = cpsr.c & ~cpsr.z;
            exec_pkg::cond_ls: cond_ok = ~cpsr.c | cpsr.z;
            exec_pkg::cond_ge: cond_ok = (cpsr.n == cpsr.v);
            exec_pkg::cond_lt: cond_ok = (cpsr.n != cpsr.v);
            exec_pkg::cond_gt: cond_ok = ~cpsr.z & (cpsr.n == cpsr.v);
            exec_pkg::cond_le: cond_ok = cpsr.z | (cpsr.n != cpsr.v);
            default:           cond_ok = 1'b1;  // AL and 1111
        endcase
    end

    assign execute = enable & cond_ok;

    always_comb begin
        next_out  = '0;
        next_cpsr = cpsr;
        if (execute) begin
            case (dp_view.format)
                exec_pkg::fmt_data: begin
                    next_out.update_rd    = dp.write_rd;
                    next_out.rd_addr      = dp.rd;
                    next_out.rd_value     = dp.value;
                    next_out.flush_for_pc = dp.write_rd && (dp.rd == exec_pkg::pc_reg);
                    if (dp_view.s) begin
                        next_cpsr = dp.flags;
                    end
                end
                exec_pkg::fmt_branch: begin
                    next_out.update_pc    = 1'b1;
                    next_out.new_pc       = br.new_pc;
                    next_out.flush_for_pc = 1'b1;
                    if (br.link) begin  // BL writes the return address
                        next_out.update_rd = 1'b1;
                        next_out.rd_addr   = exec_pkg::reg_addr_t'(exec_pkg::link_reg);
                        next_out.rd_value  = br.link_value;
                    end
                end
                default: begin
                    // Memory format is a no-op
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (nreset) begin
            ready            <= 1'b0;
            cpsr             <= '0;
            condition_passes <= 1'b0;
            executor_inst    <= '0;
            out              <= '0;
        end else begin
            ready            <= enable;
            cpsr             <= next_cpsr;
            condition_passes <= cond_ok;  // Goes with executor_inst
            executor_inst    <= inst;
            out              <= next_out;
        end
    end

endmodule

//--- logic/executor_top.sv
// ==========================================================================
// Execute stage top: one instruction per cycle in, one registered commit
// record out a cycle later
// ==========================================================================
`timescale 1ns/1ps

module executor_top (
    input  logic                clk,
    input  logic                nreset,
    input  logic                enable,
    input  exec_pkg::word_t     inst,
    input  exec_pkg::word_t     rn_value,
    input  exec_pkg::word_t     rm_value,
    input  exec_pkg::word_t     pc,
    output logic                ready,
    output exec_pkg::cpsr_t     cpsr,
    output logic                condition_passes,
    output exec_pkg::word_t     executor_inst,
    output exec_pkg::exec_out_t out
);

    exec_pkg::dp_inst_t   dp_inst;    // Data-processing view
    exec_pkg::br_inst_t   br_inst;    // Branch view
    exec_pkg::dp_result_t dp_result;
    exec_pkg::br_result_t br_result;

    assign dp_inst = exec_pkg::dp_inst_t'(inst);
    assign br_inst = exec_pkg::br_inst_t'(inst);

    dataproc_alu u_dataproc_alu (
        .inst     (dp_inst),
        .rn_value (rn_value),
        .rm_value (rm_value),
        .cpsr     (cpsr),
        .result   (dp_result)
    );

    branch_unit u_branch_unit (
        .inst   (br_inst),
        .pc     (pc),
        .result (br_result)
    );

    exec_commit u_exec_commit (
        .clk              (clk),
        .nreset           (nreset),
        .enable           (enable),
        .inst             (inst),
        .dp               (dp_result),
        .br               (br_result),
        .ready            (ready),
        .cpsr             (cpsr),
        .condition_passes (condition_passes),
        .executor_inst    (executor_inst),
        .out              (out)
    );

endmodule

//--- tb/tb_executor.sv
// ==========================================================================
// Directed testbench of the execute stage, checks every cycle against
// a behavioral model of the ARM data-processing, branch and flag rules
// ==========================================================================
`timescale 1ns/1ps

module tb_executor;

    localparam int clk_period  = 100;
    localparam int test_cycles = 200;  // Reset plus all directed tests
    localparam int margin      = 50;

    logic                clk;
    logic                nreset;
    logic                enable;
    exec_pkg::word_t     inst;
    exec_pkg::word_t     rn_value;
    exec_pkg::word_t     rm_value;
    exec_pkg::word_t     pc;
    logic                ready;
    exec_pkg::cpsr_t     cpsr;
    logic                condition_passes;
    exec_pkg::word_t     executor_inst;
    exec_pkg::exec_out_t out;

    // Expectation for the instruction driven one cycle back
    exec_pkg::exec_out_t exp_out;
    exec_pkg::cpsr_t     exp_cpsr;
    logic                exp_ready;
    logic                exp_pass;
    exec_pkg::word_t     exp_inst;

    executor_top u_executor_top (
        .clk              (clk),
        .nreset           (nreset),
        .enable           (enable),
        .inst             (inst),
        .rn_value         (rn_value),
        .rm_value         (rm_value),
        .pc               (pc),
        .ready            (ready),
        .cpsr             (cpsr),
        .condition_passes (condition_passes),
        .executor_inst    (executor_inst),
        .out              (out)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(clk_period * (test_cycles + margin));
        $display("Timeout: the tests did not finish in the expected number of cycles");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_out(input exec_pkg::exec_out_t got, input exec_pkg::exec_out_t want);
        if (got !== want) begin
            $display("ERROR at %0t: out got %h expected %h", $time, got, want);
            stop_run();
        end
    endtask

    task automatic check_cpsr(input exec_pkg::cpsr_t got, input exec_pkg::cpsr_t want);
        if (got !== want) begin
            $display("ERROR at %0t: cpsr got %b expected %b", $time, got, want);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("ERROR at %0t: %s got %b expected %b", $time, name, got, want);
            stop_run();
        end
    endtask

    task automatic check_word(input string name, input exec_pkg::word_t got,
            input exec_pkg::word_t want);
        if (got !== want) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, want);
            stop_run();
        end
    endtask

    // ARM condition table where 1110 and 1111 always pass
    function automatic logic cond_holds(input logic [3:0] cond, input exec_pkg::cpsr_t f);
        case (cond)
            4'h0: return f.z;
            4'h1: return !f.z;
            4'h2: return f.c;
            4'h3: return !f.c;
            4'h4: return f.n;
            4'h5: return !f.n;
            4'h6: return f.v;
            4'h7: return !f.v;
            4'h8: return f.c && !f.z;
            4'h9: return !f.c || f.z;
            4'ha: return f.n == f.v;
            4'hb: return f.n != f.v;
            4'hc: return !f.z && (f.n == f.v);
            4'hd: return f.z || (f.n != f.v);
            default: return 1'b1;
        endcase
    endfunction

    function automatic exec_pkg::word_t model_operand2(input logic imm, input logic [11:0] field,
            input exec_pkg::word_t rm);
        exec_pkg::word_t imm_w;
        int              n;
        imm_w = {24'd0, field[7:0]};
        if (imm) begin
            n = 2 * field[11:8];
            return (n == 0) ? imm_w : (imm_w >> n) | (imm_w << (32 - n));
        end
        n = int'(field[11:7]);
        case (field[6:5])
            2'd0: return rm << n;
            2'd1: return rm >> n;
            2'd2: return exec_pkg::word_t'($signed(rm) >>> n);
            default: return (n == 0) ? rm : (rm >> n) | (rm << (32 - n));
        endcase
    endfunction

    function automatic exec_pkg::dp_result_t model_alu(input exec_pkg::dp_inst_t di,
            input exec_pkg::word_t rn, input exec_pkg::word_t rm, input exec_pkg::cpsr_t f);
        exec_pkg::dp_result_t r;
        exec_pkg::word_t      b;
        longint               wide;  // Exact signed result
        b = model_operand2(di.imm, di.operand2, rm);
        r.write_rd = !(di.opcode inside {exec_pkg::op_tst, exec_pkg::op_teq, exec_pkg::op_cmp});
        r.rd       = di.rd;
        r.flags    = f;
        case (di.opcode)
            exec_pkg::op_eor, exec_pkg::op_teq: r.value = rn ^ b;
            exec_pkg::op_tst: r.value = rn & b;
            exec_pkg::op_orr: r.value = rn | b;
            exec_pkg::op_mov: r.value = b;
            exec_pkg::op_bic: r.value = rn & ~b;
            exec_pkg::op_mvn: r.value = ~b;
            exec_pkg::op_add: begin
                r.value   = rn + b;
                r.flags.c = ({32'd0, rn} + {32'd0, b}) > 64'hffff_ffff;
                wide      = longint'($signed(rn)) + longint'($signed(b));
                r.flags.v = wide != longint'($signed(r.value));
            end
            exec_pkg::op_sub, exec_pkg::op_cmp: begin
                r.value   = rn - b;
                r.flags.c = rn >= b;  // No borrow
                wide      = longint'($signed(rn)) - longint'($signed(b));
                r.flags.v = wide != longint'($signed(r.value));
            end
            default: r.value = rn;
        endcase
        r.flags.n = r.value[31];
        r.flags.z = (r.value == '0);
        return r;
    endfunction

    task automatic predict(input logic en, input exec_pkg::word_t ins, input exec_pkg::word_t rn,
            input exec_pkg::word_t rm, input exec_pkg::word_t p);
        exec_pkg::dp_inst_t   di;
        exec_pkg::br_inst_t   bi;
        exec_pkg::dp_result_t r;
        di        = exec_pkg::dp_inst_t'(ins);
        bi        = exec_pkg::br_inst_t'(ins);
        exp_ready = en;
        exp_inst  = ins;
        exp_pass  = cond_holds(di.cond, exp_cpsr);  // Flags before this instruction
        exp_out   = '0;
        if (en && exp_pass && di.format == exec_pkg::fmt_data) begin
            r                    = model_alu(di, rn, rm, exp_cpsr);
            exp_out.update_rd    = r.write_rd;
            exp_out.rd_addr      = di.rd;
            exp_out.rd_value     = r.value;
            exp_out.flush_for_pc = r.write_rd && (di.rd == 4'd15);
            if (di.s) begin
                exp_cpsr = r.flags;
            end
        end else if (en && exp_pass && di.format == exec_pkg::fmt_branch) begin
            exp_out.update_pc    = 1'b1;
            exp_out.new_pc       = p + exec_pkg::word_t'(4 * int'($signed(bi.offset)));
            exp_out.flush_for_pc = 1'b1;
            if (bi.link) begin
                exp_out.update_rd = 1'b1;
                exp_out.rd_addr   = 4'd14;
                exp_out.rd_value  = p - 32'd4;
            end
        end
    endtask

    // Drives one instruction and checks the one before it
    task automatic issue(input logic en, input exec_pkg::word_t ins, input exec_pkg::word_t rn,
            input exec_pkg::word_t rm, input exec_pkg::word_t p);
        @(posedge clk);
        enable   <= en;
        inst     <= ins;
        rn_value <= rn;
        rm_value <= rm;
        pc       <= p;
        @(negedge clk);
        check_out(out, exp_out);
        check_cpsr(cpsr, exp_cpsr);
        check_bit("ready", ready, exp_ready);
        check_bit("condition_passes", condition_passes, exp_pass);
        check_word("executor_inst", executor_inst, exp_inst);
        predict(en, ins, rn, rm, p);
    endtask

    function automatic exec_pkg::word_t dp_word(input logic [3:0] cond, input logic imm,
            input logic [3:0] op, input logic s, input logic [3:0] rn, input logic [3:0] rd,
            input logic [11:0] op2);
        return {cond, 2'b00, imm, op, s, rn, rd, op2};
    endfunction

    task automatic reset_state();
        check_out(out, '0);
        check_cpsr(cpsr, '0);
        check_bit("ready", ready, 1'b0);
        check_bit("condition_passes", condition_passes, 1'b0);
        check_word("executor_inst", executor_inst, '0);
        predict(1'b0, '0, '0, '0, '0);  // Idle inputs still held
    endtask

    task automatic all_data_ops();
        exec_pkg::word_t ins;
        logic [11:0]     op2;
        for (int k = 0; k < 16; k++) begin
            if (!(k inside {1, 2, 4, 8, 9, 10, 12, 13, 14, 15})) begin
                continue;
            end
            // Mode 0 is the rotated immediate and 1 to 4 are LSL, LSR, ASR, ROR
            for (int mode = 0; mode < 5; mode++) begin
                if (mode == 0) begin
                    op2 = 12'($urandom);
                end else begin
                    op2 = {5'($urandom), 2'(mode - 1), 5'd2};
                end
                ins = dp_word(4'he, mode == 0, 4'(k), 1'($urandom), 4'($urandom),
                              4'($urandom), op2);
                issue(1'b1, ins, $urandom, $urandom, $urandom);
            end
        end
    endtask

    task automatic flag_updates();
        exec_pkg::word_t adds;
        exec_pkg::word_t subs;
        exec_pkg::word_t cmp_w;
        adds  = dp_word(4'he, 1'b0, 4'b0100, 1'b1, 4'd1, 4'd2, 12'd2);  // Rm with LSL 0
        subs  = dp_word(4'he, 1'b0, 4'b0010, 1'b1, 4'd1, 4'd2, 12'd2);
        cmp_w = dp_word(4'he, 1'b0, 4'b1010, 1'b1, 4'd1, 4'd0, 12'd2);
        issue(1'b1, adds, 32'hffff_ffff, 32'd1, '0);   // Carry and zero
        issue(1'b1, adds, 32'h7fff_ffff, 32'd1, '0);   // Signed overflow
        issue(1'b1, subs, 32'd1, 32'd2, '0);           // Borrow
        issue(1'b1, subs, 32'h8000_0000, 32'd1, '0);
        issue(1'b1, cmp_w, 32'd7, 32'd7, '0);
        // Flags hold without the S bit
        issue(1'b1, dp_word(4'he, 1'b0, 4'b0100, 1'b0, 4'd1, 4'd2, 12'd2), 32'd1, 32'd1, '0);
    endtask

    task automatic condition_table();
        exec_pkg::word_t rn_set[4] = '{32'd5, 32'd1, 32'h8000_0000, 32'd3};
        exec_pkg::word_t rm_set[4] = '{32'd5, 32'd2, 32'd1, 32'd1};
        exec_pkg::word_t cmp_w;
        int              sel;
        cmp_w = dp_word(4'he, 1'b0, 4'b1010, 1'b1, 4'd0, 4'd0, 12'd2);
        for (int f = 0; f < 4; f++) begin
            for (int c = 0; c < 15; c++) begin
                sel = (f + c) % 4;  // New flags on every pair
                issue(1'b1, cmp_w, rn_set[sel], rm_set[sel], '0);
                issue(1'b1, dp_word(4'(c), 1'b1, 4'b1101, 1'b0, 4'd0, 4'd1, 12'(c + 1)),
                      '0, '0, '0);
            end
        end
    endtask

    task automatic branch_targets();
        int              offsets[4] = '{5, -3, -64, 256};
        exec_pkg::word_t base;
        for (int k = 0; k < 4; k++) begin
            base = 32'h1000 + ($urandom & 32'hfff0);
            issue(1'b1, {4'he, 2'b10, 1'b1, k[0], 24'(offsets[k])}, '0, '0, base);  // Odd k is BL
        end
    endtask

    task automatic flush_and_idle();
        issue(1'b1, dp_word(4'he, 1'b1, 4'b1101, 1'b0, 4'd0, 4'd15, 12'h040), '0, '0, '0);
        issue(1'b1, {4'he, 2'b01, 26'($urandom)}, $urandom, $urandom, $urandom);
        issue(1'b0, dp_word(4'he, 1'b1, 4'b1101, 1'b1, 4'd0, 4'd3, 12'h0ff), '0, '0, '0);
        issue(1'b0, {4'he, 2'b10, 1'b1, 1'b1, 24'd8}, '0, '0, 32'h2000);
    endtask

    initial begin
        void'($urandom(34));
        nreset    = 1'b1;
        enable    = 1'b0;
        inst      = '0;
        rn_value  = '0;
        rm_value  = '0;
        pc        = '0;
        exp_out   = '0;
        exp_cpsr  = '0;
        exp_ready = 1'b0;
        exp_pass  = 1'b0;
        exp_inst  = '0;
        repeat (3) @(posedge clk);
        nreset <= 1'b0;
        @(negedge clk);
        reset_state();
        all_data_ops();
        flag_updates();
        condition_table();
        branch_targets();
        flush_and_idle();
        issue(1'b0, '0, '0, '0, '0);  // Drain the last instruction
        $display("Test OK");
        $finish;
    end

endmodule

//--- src.f
common/exec_pkg.sv
dataproc/operand_shifter.sv
dataproc/dataproc_alu.sv
logic/branch_unit.sv
logic/exec_commit.sv
logic/executor_top.sv
tb/tb_executor.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_executor
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_TEXT ?= Test OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	@result="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$result"; \
	echo "$$result" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
